// ==== design/xbar_pkg.sv ====
`default_nettype none

package xbar_pkg;

	localparam int DATA_WIDTH        = 32;
	localparam int NUM_INPUT_DATA    = 8;
	localparam int NUM_OUTPUT_DATA   = 8;

	// bit (in*NUM_OUTPUT_DATA + out) set -> input drives output
	localparam int TOTAL_COMMAND     = NUM_INPUT_DATA * NUM_OUTPUT_DATA;

	localparam int WIDTH_INPUT_DATA  = NUM_INPUT_DATA * DATA_WIDTH;
	localparam int WIDTH_OUTPUT_DATA = NUM_OUTPUT_DATA * DATA_WIDTH;

	localparam int LANE_IDX_W        = 3;

	localparam int NUM_IN_WIRE_PIPELINE  = 5;
	localparam int NUM_OUT_WIRE_PIPELINE = 3; // mux register counts as stage 0

	// input stages + output stages + final register
	localparam int XBAR_LATENCY = NUM_IN_WIRE_PIPELINE + NUM_OUT_WIRE_PIPELINE + 1;

	// one more for the lane merge register
	localparam int TOP_LATENCY  = XBAR_LATENCY + 1;

endpackage

`default_nettype wire

// ==== design/crossbar_one_hot_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module crossbar_one_hot_seq
	import xbar_pkg::*;
(
	input  logic                         clk,
	input  logic                         i_rst_n,

	input  logic [NUM_INPUT_DATA-1:0]    i_valid,
	input  logic [WIDTH_INPUT_DATA-1:0]  i_data_bus,
	input  logic                         i_en,
	input  logic [TOTAL_COMMAND-1:0]     i_cmd,

	output logic [NUM_OUTPUT_DATA-1:0]   o_valid,
	output logic [WIDTH_OUTPUT_DATA-1:0] o_data_bus
);

	// input pipeline, command and enable travel with the data
	logic [NUM_INPUT_DATA-1:0]    in_valid_q [NUM_IN_WIRE_PIPELINE];
	logic [WIDTH_INPUT_DATA-1:0]  in_data_q  [NUM_IN_WIRE_PIPELINE];
	logic [TOTAL_COMMAND-1:0]     in_cmd_q   [NUM_IN_WIRE_PIPELINE];
	logic                         in_en_q    [NUM_IN_WIRE_PIPELINE];

	// output pipeline, stage 0 is the mux register
	logic [NUM_OUTPUT_DATA-1:0]   out_valid_q [NUM_OUT_WIRE_PIPELINE];
	logic [WIDTH_OUTPUT_DATA-1:0] out_data_q  [NUM_OUT_WIRE_PIPELINE];

	logic [NUM_OUTPUT_DATA-1:0]   mux_valid;
	logic [WIDTH_OUTPUT_DATA-1:0] mux_data;

	logic [NUM_OUTPUT_DATA-1:0]   valid_reg;
	logic [WIDTH_OUTPUT_DATA-1:0] data_reg;

	localparam int LAST_IN = NUM_IN_WIRE_PIPELINE - 1;
	localparam int LAST_OUT = NUM_OUT_WIRE_PIPELINE - 1;

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			for (int s = 0; s < NUM_IN_WIRE_PIPELINE; s++)
			begin
				in_valid_q[s] <= '0;
				in_data_q[s]  <= '0;
				in_cmd_q[s]   <= '0;
				in_en_q[s]    <= 1'b0;
			end
		end
		else
		begin
			in_valid_q[0] <= i_valid;
			in_data_q[0]  <= i_data_bus;
			in_cmd_q[0]   <= i_cmd;
			in_en_q[0]    <= i_en;
			for (int s = 1; s < NUM_IN_WIRE_PIPELINE; s++)
			begin
				in_valid_q[s] <= in_valid_q[s-1];
				in_data_q[s]  <= in_data_q[s-1];
				in_cmd_q[s]   <= in_cmd_q[s-1];
				in_en_q[s]    <= in_en_q[s-1];
			end
		end
	end

	// column gather and select, one output lane at a time
	always_comb
	begin
		logic [NUM_INPUT_DATA-1:0] sel;
		logic                      one_hot;
		logic [DATA_WIDTH-1:0]     word;
		logic                      word_vld;

		mux_valid = '0;
		mux_data  = '0;
		for (int o = 0; o < NUM_OUTPUT_DATA; o++)
		begin
			for (int n = 0; n < NUM_INPUT_DATA; n++)
				sel[n] = in_cmd_q[LAST_IN][n*NUM_OUTPUT_DATA + o];

			// exactly one bit set
			one_hot = (sel != '0) && ((sel & (sel - 1'b1)) == '0);

			word     = '0;
			word_vld = 1'b0;
			for (int n = 0; n < NUM_INPUT_DATA; n++)
			begin
				if (sel[n] && in_valid_q[LAST_IN][n])
				begin
					word     = word | in_data_q[LAST_IN][n*DATA_WIDTH +: DATA_WIDTH];
					word_vld = 1'b1;
				end
			end

			if (in_en_q[LAST_IN] && one_hot && word_vld)
			begin
				mux_valid[o]                       = 1'b1;
				mux_data[o*DATA_WIDTH +: DATA_WIDTH] = word;
			end
		end
	end

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			for (int s = 0; s < NUM_OUT_WIRE_PIPELINE; s++)
			begin
				out_valid_q[s] <= '0;
				out_data_q[s]  <= '0;
			end
			valid_reg <= '0;
			data_reg  <= '0;
		end
		else
		begin
			out_valid_q[0] <= mux_valid;
			out_data_q[0]  <= mux_data;
			for (int s = 1; s < NUM_OUT_WIRE_PIPELINE; s++)
			begin
				out_valid_q[s] <= out_valid_q[s-1];
				out_data_q[s]  <= out_data_q[s-1];
			end
			valid_reg <= out_valid_q[LAST_OUT]; // final register
			data_reg  <= out_data_q[LAST_OUT];
		end
	end

	assign o_valid    = valid_reg;
	assign o_data_bus = data_reg;

endmodule

`default_nettype wire

// ==== design/route_cfg_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module route_cfg_loader
	import xbar_pkg::*;
(
	input  logic                     clk,
	input  logic                     i_rst_n,

	input  logic                     i_cfg_req,
	input  logic                     i_cfg_fabric, // 0 = A, 1 = B
	input  logic [LANE_IDX_W-1:0]    i_cfg_out,
	input  logic [LANE_IDX_W-1:0]    i_cfg_in,
	input  logic                     i_cfg_link,
	output logic                     o_cfg_ack,

	output logic [TOTAL_COMMAND-1:0] o_cmd_a,
	output logic [TOTAL_COMMAND-1:0] o_cmd_b
);

	logic                     ack_q;
	logic [TOTAL_COMMAND-1:0] cmd_a_q;
	logic [TOTAL_COMMAND-1:0] cmd_b_q;
	logic [TOTAL_COMMAND-1:0] col_mask;  // bits of the addressed column
	logic [TOTAL_COMMAND-1:0] col_value; // new contents of that column
	logic                     accept;

	// one write per transfer, only while ack is still low
	assign accept = i_cfg_req && !ack_q;

	always_comb
	begin
		col_mask  = '0;
		col_value = '0;
		for (int n = 0; n < NUM_INPUT_DATA; n++)
		begin
			col_mask[n*NUM_OUTPUT_DATA + i_cfg_out] = 1'b1;
			if (i_cfg_link && (n == int'(i_cfg_in)))
				col_value[n*NUM_OUTPUT_DATA + i_cfg_out] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			ack_q <= 1'b0;
		end
		else if (accept)
		begin
			ack_q <= 1'b1;
		end
		else if (!i_cfg_req)
		begin
			ack_q <= 1'b0; // host released req
		end
	end

	// matrices update on the same edge ack rises
	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			cmd_a_q <= '0;
			cmd_b_q <= '0;
		end
		else if (accept)
		begin
			if (i_cfg_fabric)
				cmd_b_q <= (cmd_b_q & ~col_mask) | col_value;
			else
				cmd_a_q <= (cmd_a_q & ~col_mask) | col_value;
		end
	end

	assign o_cfg_ack = ack_q;
	assign o_cmd_a   = cmd_a_q;
	assign o_cmd_b   = cmd_b_q;

endmodule

`default_nettype wire

// ==== design/lane_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_merge
	import xbar_pkg::*;
(
	input  logic                         clk,
	input  logic                         i_rst_n,

	input  logic [NUM_OUTPUT_DATA-1:0]   i_valid_a,
	input  logic [WIDTH_OUTPUT_DATA-1:0] i_data_a,
	input  logic [NUM_OUTPUT_DATA-1:0]   i_valid_b,
	input  logic [WIDTH_OUTPUT_DATA-1:0] i_data_b,

	output logic [NUM_OUTPUT_DATA-1:0]   o_valid,
	output logic [WIDTH_OUTPUT_DATA-1:0] o_data_bus
);

	logic [NUM_OUTPUT_DATA-1:0]   valid_q;
	logic [WIDTH_OUTPUT_DATA-1:0] data_q;

	always_ff @(posedge clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			valid_q <= '0;
			data_q  <= '0;
		end
		else
		begin
			for (int l = 0; l < NUM_OUTPUT_DATA; l++)
			begin
				valid_q[l] <= i_valid_a[l] | i_valid_b[l];
				case ({i_valid_a[l], i_valid_b[l]})
					2'b11:
						// wraps mod 2^32, carry dropped
						data_q[l*DATA_WIDTH +: DATA_WIDTH] <=
							i_data_a[l*DATA_WIDTH +: DATA_WIDTH] +
							i_data_b[l*DATA_WIDTH +: DATA_WIDTH];
					2'b10:
						data_q[l*DATA_WIDTH +: DATA_WIDTH] <= i_data_a[l*DATA_WIDTH +: DATA_WIDTH];
					2'b01:
						data_q[l*DATA_WIDTH +: DATA_WIDTH] <= i_data_b[l*DATA_WIDTH +: DATA_WIDTH];
					default:
						data_q[l*DATA_WIDTH +: DATA_WIDTH] <= '0;
				endcase
			end
		end
	end

	assign o_valid    = valid_q;
	assign o_data_bus = data_q;

endmodule

`default_nettype wire

// ==== design/dual_xbar_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_xbar_top
	import xbar_pkg::*;
(
	input  logic                         clk,
	input  logic                         i_rst_n,

	input  logic [NUM_INPUT_DATA-1:0]    i_valid,
	input  logic [WIDTH_INPUT_DATA-1:0]  i_data_bus,
	input  logic                         i_en,

	input  logic                         i_cfg_req,
	input  logic                         i_cfg_fabric,
	input  logic [LANE_IDX_W-1:0]        i_cfg_out,
	input  logic [LANE_IDX_W-1:0]        i_cfg_in,
	input  logic                         i_cfg_link,
	output logic                         o_cfg_ack,

	output logic [NUM_OUTPUT_DATA-1:0]   o_valid,
	output logic [WIDTH_OUTPUT_DATA-1:0] o_data_bus
);

	logic [TOTAL_COMMAND-1:0]     cmd_a;
	logic [TOTAL_COMMAND-1:0]     cmd_b;
	logic [NUM_OUTPUT_DATA-1:0]   valid_a;
	logic [WIDTH_OUTPUT_DATA-1:0] data_a;
	logic [NUM_OUTPUT_DATA-1:0]   valid_b;
	logic [WIDTH_OUTPUT_DATA-1:0] data_b;

	route_cfg_loader cfg_i (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_cfg_req    (i_cfg_req),
		.i_cfg_fabric (i_cfg_fabric),
		.i_cfg_out    (i_cfg_out),
		.i_cfg_in     (i_cfg_in),
		.i_cfg_link   (i_cfg_link),
		.o_cfg_ack    (o_cfg_ack),
		.o_cmd_a      (cmd_a),
		.o_cmd_b      (cmd_b)
	);

	// both fabrics see the same input lanes
	crossbar_one_hot_seq xbar_a_i (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_valid    (i_valid),
		.i_data_bus (i_data_bus),
		.i_en       (i_en),
		.i_cmd      (cmd_a),
		.o_valid    (valid_a),
		.o_data_bus (data_a)
	);

	crossbar_one_hot_seq xbar_b_i (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_valid    (i_valid),
		.i_data_bus (i_data_bus),
		.i_en       (i_en),
		.i_cmd      (cmd_b),
		.o_valid    (valid_b),
		.o_data_bus (data_b)
	);

	lane_merge merge_i (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_valid_a  (valid_a),
		.i_data_a   (data_a),
		.i_valid_b  (valid_b),
		.i_data_b   (data_b),
		.o_valid    (o_valid),
		.o_data_bus (o_data_bus)
	);

endmodule

`default_nettype wire

// ==== verification/tb_dual_xbar.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dual_xbar
	import xbar_pkg::*;
;

	localparam int CLK_PERIOD   = 100;
	localparam int NUM_WRITES   = 18;
	localparam int WRITE_CYCLES = 12; // req edge, ack limit, release
	localparam int NUM_WORDS    = 90;
	localparam int NUM_DRAINS   = 6;
	localparam int MAX_CYCLES   = 10 + NUM_WRITES * WRITE_CYCLES + NUM_WORDS
		+ NUM_DRAINS * (TOP_LATENCY + 2) + 100;

	logic                         clk = 1'b0;
	logic                         i_rst_n;
	logic [NUM_INPUT_DATA-1:0]    i_valid;
	logic [WIDTH_INPUT_DATA-1:0]  i_data_bus;
	logic                         i_en;
	logic                         i_cfg_req;
	logic                         i_cfg_fabric;
	logic [LANE_IDX_W-1:0]        i_cfg_out;
	logic [LANE_IDX_W-1:0]        i_cfg_in;
	logic                         i_cfg_link;
	logic                         o_cfg_ack;
	logic [NUM_OUTPUT_DATA-1:0]   o_valid;
	logic [WIDTH_OUTPUT_DATA-1:0] o_data_bus;

	// testbench copies of the two route matrices
	logic [TOTAL_COMMAND-1:0]     model_a = '0;
	logic [TOTAL_COMMAND-1:0]     model_b = '0;

	logic [NUM_OUTPUT_DATA-1:0]   exp_valid_q [$];
	logic [WIDTH_OUTPUT_DATA-1:0] exp_data_q [$];
	logic [NUM_OUTPUT_DATA-1:0]   pred_valid;
	logic [WIDTH_OUTPUT_DATA-1:0] pred_data;
	logic [NUM_OUTPUT_DATA-1:0]   due_valid;
	logic [WIDTH_OUTPUT_DATA-1:0] due_data;

	dual_xbar_top dut_i (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_valid      (i_valid),
		.i_data_bus   (i_data_bus),
		.i_en         (i_en),
		.i_cfg_req    (i_cfg_req),
		.i_cfg_fabric (i_cfg_fabric),
		.i_cfg_out    (i_cfg_out),
		.i_cfg_in     (i_cfg_in),
		.i_cfg_link   (i_cfg_link),
		.o_cfg_ack    (o_cfg_ack),
		.o_valid      (o_valid),
		.o_data_bus   (o_data_bus)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [WIDTH_OUTPUT_DATA-1:0] got,
			input logic [WIDTH_OUTPUT_DATA-1:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got=%h exp=%h at %0t", name, got, exp, $time);
			$display("ERRORS FOUND");
			$fatal(1, "stopping on first mismatch");
		end
	endtask

	function automatic logic [WIDTH_INPUT_DATA-1:0] rand_bus(input logic [DATA_WIDTH-1:0] top_bits);
		logic [WIDTH_INPUT_DATA-1:0] bus;
		for (int l = 0; l < NUM_INPUT_DATA; l++)
			bus[l*DATA_WIDTH +: DATA_WIDTH] = $urandom() | top_bits;
		return bus;
	endfunction

	// {valid, word} of one output lane on one fabric
	function automatic logic [DATA_WIDTH:0] route_lane(input logic [TOTAL_COMMAND-1:0] mat,
			input int lane, input logic [NUM_INPUT_DATA-1:0] vld,
			input logic [WIDTH_INPUT_DATA-1:0] bus, input logic en);
		int hits;
		int src;
		hits = 0;
		src  = 0;
		for (int n = 0; n < NUM_INPUT_DATA; n++)
		begin
			if (mat[n*NUM_OUTPUT_DATA + lane])
			begin
				hits++;
				src = n;
			end
		end
		if (en && hits == 1 && vld[src])
			return {1'b1, bus[src*DATA_WIDTH +: DATA_WIDTH]};
		return '0;
	endfunction

	task automatic predict_output(input logic [NUM_INPUT_DATA-1:0] vld,
			input logic [WIDTH_INPUT_DATA-1:0] bus, input logic en,
			output logic [NUM_OUTPUT_DATA-1:0] exp_valid,
			output logic [WIDTH_OUTPUT_DATA-1:0] exp_data);
		logic [DATA_WIDTH:0] from_a;
		logic [DATA_WIDTH:0] from_b;
		exp_valid = '0;
		exp_data  = '0;
		for (int o = 0; o < NUM_OUTPUT_DATA; o++)
		begin
			from_a = route_lane(model_a, o, vld, bus, en);
			from_b = route_lane(model_b, o, vld, bus, en);
			exp_valid[o] = from_a[DATA_WIDTH] | from_b[DATA_WIDTH];
			if (from_a[DATA_WIDTH] && from_b[DATA_WIDTH])
				exp_data[o*DATA_WIDTH +: DATA_WIDTH] =
					from_a[DATA_WIDTH-1:0] + from_b[DATA_WIDTH-1:0]; // mod 2^32
			else if (from_a[DATA_WIDTH])
				exp_data[o*DATA_WIDTH +: DATA_WIDTH] = from_a[DATA_WIDTH-1:0];
			else if (from_b[DATA_WIDTH])
				exp_data[o*DATA_WIDTH +: DATA_WIDTH] = from_b[DATA_WIDTH-1:0];
		end
	endtask

	// column gets a single one or is emptied
	task automatic apply_column(input logic fabric, input logic [LANE_IDX_W-1:0] out_lane,
			input logic [LANE_IDX_W-1:0] in_lane, input logic link);
		logic [TOTAL_COMMAND-1:0] mat;
		mat = fabric ? model_b : model_a;
		for (int n = 0; n < NUM_INPUT_DATA; n++)
			mat[n*NUM_OUTPUT_DATA + int'(out_lane)] = link && (n == int'(in_lane));
		if (fabric)
			model_b = mat;
		else
			model_a = mat;
	endtask

	// inputs of the word now on the bus enter the DUT at the next edge
	always @(negedge clk)
	begin
		if (i_rst_n)
		begin
			predict_output(i_valid, i_data_bus, i_en, pred_valid, pred_data);
			exp_valid_q.push_back(pred_valid);
			exp_data_q.push_back(pred_data);
			if (exp_valid_q.size() > TOP_LATENCY)
			begin
				due_valid = exp_valid_q.pop_front();
				due_data  = exp_data_q.pop_front();
				check_value("o_valid", WIDTH_OUTPUT_DATA'(o_valid), WIDTH_OUTPUT_DATA'(due_valid));
				check_value("o_data_bus", o_data_bus, due_data);
			end
		end
	end

	task automatic send_word(input logic [NUM_INPUT_DATA-1:0] vld,
			input logic [WIDTH_INPUT_DATA-1:0] bus, input logic en);
		@(posedge clk);
		i_valid    <= vld;
		i_data_bus <= bus;
		i_en       <= en;
	endtask

	task automatic drain_pipeline();
		repeat (TOP_LATENCY + 2)
			send_word('0, '0, 1'b0);
	endtask

	task automatic wait_ack();
		int waited;
		waited = 1;
		@(posedge clk);
		#1;
		while (!o_cfg_ack && waited < 8)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!o_cfg_ack)
		begin
			$display("no ack from the config loader within 8 cycles of req");
			$display("ERRORS FOUND");
			$fatal(1, "config handshake stalled");
		end
	endtask

	// ack must drop on the first edge that sees req low
	task automatic wait_release();
		@(posedge clk);
		#1;
		check_value("o_cfg_ack", WIDTH_OUTPUT_DATA'(o_cfg_ack), '0);
	endtask

	task automatic cfg_write(input logic fabric, input logic [LANE_IDX_W-1:0] out_lane,
			input logic [LANE_IDX_W-1:0] in_lane, input logic link);
		@(posedge clk);
		i_cfg_req    <= 1'b1;
		i_cfg_fabric <= fabric;
		i_cfg_out    <= out_lane;
		i_cfg_in     <= in_lane;
		i_cfg_link   <= link;
		wait_ack();
		apply_column(fabric, out_lane, in_lane, link);
		@(posedge clk);
		i_cfg_req <= 1'b0;
		wait_release();
	endtask

	task automatic check_reset_state();
		@(negedge clk);
		check_value("o_cfg_ack", WIDTH_OUTPUT_DATA'(o_cfg_ack), '0);
		check_value("o_valid", WIDTH_OUTPUT_DATA'(o_valid), '0);
		check_value("o_data_bus", o_data_bus, '0);
		// nothing gets through empty matrices
		repeat (6)
			send_word('1, rand_bus('0), 1'b1);
		drain_pipeline();
	endtask

	task automatic check_handshake();
		@(posedge clk);
		i_cfg_req    <= 1'b1;
		i_cfg_fabric <= 1'b0;
		i_cfg_out    <= 3'd0;
		i_cfg_in     <= 3'd3;
		i_cfg_link   <= 1'b1;
		#1;
		check_value("o_cfg_ack", WIDTH_OUTPUT_DATA'(o_cfg_ack), '0); // req not seen yet
		wait_ack();
		apply_column(1'b0, 3'd0, 3'd3, 1'b1);
		// a repeated write would now route lane 1
		@(posedge clk);
		i_cfg_out <= 3'd1;
		i_cfg_in  <= 3'd2;
		repeat (4)
		begin
			@(posedge clk);
			#1;
			check_value("o_cfg_ack", WIDTH_OUTPUT_DATA'(o_cfg_ack), WIDTH_OUTPUT_DATA'(1'b1));
		end
		@(posedge clk);
		i_cfg_req <= 1'b0;
		wait_release();
		repeat (4)
			send_word('1, rand_bus('0), 1'b1);
		drain_pipeline();
	endtask

	task automatic route_fabric_a();
		for (int o = 0; o < NUM_OUTPUT_DATA; o++)
			cfg_write(1'b0, LANE_IDX_W'(o), LANE_IDX_W'((o * 5 + 3) % NUM_INPUT_DATA), 1'b1);
		repeat (20)
			send_word('1, rand_bus('0), 1'b1); // back to back
		drain_pipeline();
	endtask

	task automatic merge_fabrics();
		// lanes 6 and 7 stay on A only
		for (int o = 0; o < 6; o++)
			cfg_write(1'b1, LANE_IDX_W'(o), LANE_IDX_W'((o + 1) % NUM_INPUT_DATA), 1'b1);
		repeat (20)
			send_word(NUM_INPUT_DATA'($urandom()), rand_bus('0), 1'b1);
		repeat (4)
			send_word('1, rand_bus(32'hf000_0000), 1'b1); // sums wrap
		drain_pipeline();
	endtask

	task automatic drop_enable_and_valid();
		for (int k = 0; k < 24; k++)
			send_word(NUM_INPUT_DATA'($urandom()), rand_bus('0), (k % 3) != 1);
		send_word('0, rand_bus('0), 1'b1);
		drain_pipeline();
	endtask

	task automatic unlink_columns();
		cfg_write(1'b0, 3'd2, 3'd0, 1'b0);
		cfg_write(1'b1, 3'd2, 3'd0, 1'b0);
		cfg_write(1'b1, 3'd4, 3'd0, 1'b0); // lane 4 back to A only
		repeat (8)
			send_word('1, rand_bus('0), 1'b1);
		drain_pipeline();
	endtask

	initial
	begin
		#(MAX_CYCLES * CLK_PERIOD);
		$display("timeout after %0d cycles, the test sequence did not finish", MAX_CYCLES);
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		i_rst_n      <= 1'b0;
		i_valid      <= '0;
		i_data_bus   <= '0;
		i_en         <= 1'b0;
		i_cfg_req    <= 1'b0;
		i_cfg_fabric <= 1'b0;
		i_cfg_out    <= '0;
		i_cfg_in     <= '0;
		i_cfg_link   <= 1'b0;
		void'($urandom(32'hc37d));
		repeat (10)
			@(posedge clk);
		i_rst_n <= 1'b1;

		check_reset_state();
		check_handshake();
		route_fabric_a();
		merge_fabrics();
		drop_enable_and_valid();
		unlink_columns();

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/xbar_pkg.sv
design/crossbar_one_hot_seq.sv
design/route_cfg_loader.sv
design/lane_merge.sv
design/dual_xbar_top.sv
verification/tb_dual_xbar.sv

// ==== Makefile ====
# Verilator build and run of the dual crossbar testbench

TOP := tb_dual_xbar
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
